/* verilog/modmul_pkg.sv */
/* Shared widths and sequencer state codes for the modular multiplier.
   Import with a wildcard in the module body, or use scoped names in headers. */

`default_nettype none

package modmul_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Operands, modulus and result
  localparam int DATA_WIDTH = 16;

  // Vector length and element counter
  localparam int INDEX_WIDTH = 8;

  // Partial remainder, 2*rem + b stays below 3*modulus
  localparam int ACC_WIDTH = DATA_WIDTH + 2;

  // Bit step counter, holds 0 to DATA_WIDTH
  localparam int COUNT_WIDTH = $clog2(DATA_WIDTH + 1);

  ////////////////////////////////////////////////////////////
  // Sequencer states
  ////////////////////////////////////////////////////////////

  // Waiting for a vector start
  localparam logic [1:0] STATE_IDLE = 2'd0;

  // Gathering the A and B elements of one pair
  localparam logic [1:0] STATE_COLLECT = 2'd1;

  // Scalar multiply in flight
  localparam logic [1:0] STATE_WAIT = 2'd2;

endpackage

`default_nettype wire

/* verilog/scalar_mul_if.sv */
/* Request and result lines between the vector sequencer and the scalar multiplier.
   Sequencer takes the requester side, multiplier the server side. */

`timescale 1ns/100ps
`default_nettype none

interface scalar_mul_if;
  import modmul_pkg::*;

  // Request, one-cycle pulse
  logic                  start;
  // Operands, held from start until ready
  logic [DATA_WIDTH-1:0] modulo;
  logic [DATA_WIDTH-1:0] a;
  logic [DATA_WIDTH-1:0] b;

  // Completion, one-cycle pulse
  logic                  ready;
  // Valid while ready is high
  logic [DATA_WIDTH-1:0] product;

  // Sequencer side
  modport requester (output start, modulo, a, b, input ready, product);

  // Multiplier side
  modport server (input start, modulo, a, b, output ready, product);

endinterface

`default_nettype wire

/* verilog/scalar_modular_multiplier.sv */
/* Bit-serial interleaved modular multiplier, product = a * b mod modulo.
   One bit of a per cycle; ready comes DATA_WIDTH + 1 cycles after start. */

`timescale 1ns/100ps
`default_nettype none

module scalar_modular_multiplier (
  input logic          CLK,
  input logic          RST,
  scalar_mul_if.server mul
);
  import modmul_pkg::*;

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  // Control
  logic                   busy;
  logic [COUNT_WIDTH-1:0] bit_count;

  // A bits, consumed MSB first
  logic [DATA_WIDTH-1:0]  a_shift;

  // Partial remainder, always below modulo
  logic [ACC_WIDTH-1:0]   acc;

  // One step of the recurrence
  logic [ACC_WIDTH-1:0]   modulo_wide;
  logic [ACC_WIDTH-1:0]   addend;
  logic [ACC_WIDTH-1:0]   doubled;
  logic [ACC_WIDTH-1:0]   first_sub;
  logic [ACC_WIDTH-1:0]   next_acc;

  // Load and step qualifiers
  logic                   load;
  logic                   step;

  ////////////////////////////////////////////////////////////
  // Step datapath
  ////////////////////////////////////////////////////////////

  assign load = !busy && mul.start;
  assign step = busy && (bit_count != '0);

  // Zero-extend the operands to the remainder width
  assign modulo_wide = ACC_WIDTH'(mul.modulo);

  // Add b only when the current top bit of A is set
  assign addend = a_shift[DATA_WIDTH-1] ? ACC_WIDTH'(mul.b) : '0;

  // rem*2 + b, below 3*modulo while rem < modulo and b < modulo
  assign doubled = (acc << 1) + addend;

  // First conditional subtraction
  assign first_sub = (doubled >= modulo_wide) ? doubled - modulo_wide : doubled;

  // Second one, result back below modulo
  assign next_acc = (first_sub >= modulo_wide) ? first_sub - modulo_wide : first_sub;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  // Idle until start, then DATA_WIDTH steps, then one ready cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy      <= 1'b0;
      bit_count <= '0;
      mul.ready <= 1'b0;
    end else begin
      // Pulse only
      mul.ready <= 1'b0;

      if (load) begin
        busy      <= 1'b1;
        bit_count <= COUNT_WIDTH'(DATA_WIDTH);
      end else if (step) begin
        bit_count <= bit_count - 1'b1;
      end else if (busy) begin
        // All bits consumed, acc holds the product
        busy      <= 1'b0;
        mul.ready <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (load) begin
      a_shift <= mul.a;
      acc     <= '0;
    end else if (step) begin
      // Next bit of A moves to the top
      a_shift <= {a_shift[DATA_WIDTH-2:0], 1'b0};
      acc     <= next_acc;
    end
  end

  // Remainder is held after the last step, so it is stable during ready
  assign mul.product = acc[DATA_WIDTH-1:0];

endmodule

`default_nettype wire

/* verilog/vector_modular_multiplier.sv */
/* Vector sequencer: gathers A and B element pairs from strobes, runs one scalar
   multiply per pair, emits each result as a strobe and pulses ready at the end. */

`timescale 1ns/100ps
`default_nettype none

module vector_modular_multiplier (
  input  logic                              CLK,
  input  logic                              RST,

  // Control
  input  logic                              start,
  output logic                              ready,
  input  logic                              data_a_enable,
  input  logic                              data_b_enable,
  output logic                              data_out_enable,

  // Data
  input  logic [modmul_pkg::DATA_WIDTH-1:0]  modulo,
  input  logic [modmul_pkg::INDEX_WIDTH-1:0] size,
  input  logic [modmul_pkg::DATA_WIDTH-1:0]  data_a,
  input  logic [modmul_pkg::DATA_WIDTH-1:0]  data_b,
  output logic [modmul_pkg::DATA_WIDTH-1:0]  data_out,

  // Scalar multiplier
  scalar_mul_if.requester                   mul
);
  import modmul_pkg::*;

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  // FSM
  logic [1:0]             state;

  // Pair bookkeeping
  logic                   a_seen;
  logic                   b_seen;
  logic                   a_done;
  logic                   b_done;
  logic                   pair_done;

  // Vector length and position
  logic [INDEX_WIDTH-1:0] size_q;
  logic [INDEX_WIDTH-1:0] index;
  logic                   last_element;

  // Held operands for the scalar multiply
  logic [DATA_WIDTH-1:0]  a_hold;
  logic [DATA_WIDTH-1:0]  b_hold;
  logic [DATA_WIDTH-1:0]  modulo_q;

  ////////////////////////////////////////////////////////////
  // Pair completion
  ////////////////////////////////////////////////////////////

  // A strobe in this cycle counts as seen
  assign a_done    = a_seen || data_a_enable;
  assign b_done    = b_seen || data_b_enable;
  assign pair_done = (state == STATE_COLLECT) && a_done && b_done;

  assign last_element = (index == size_q - INDEX_WIDTH'(1));

  // Operands straight from the hold registers
  assign mul.a      = a_hold;
  assign mul.b      = b_hold;
  assign mul.modulo = modulo_q;

  ////////////////////////////////////////////////////////////
  // Operand capture
  ////////////////////////////////////////////////////////////

  // Strobes outside collect are dropped, so operands stay put during a multiply
  always_ff @(posedge CLK) begin
    if (state == STATE_COLLECT) begin
      if (data_a_enable) begin
        a_hold <= data_a;
      end
      if (data_b_enable) begin
        b_hold <= data_b;
      end
      // Modulus taken when the pair completes
      if (a_done && b_done) begin
        modulo_q <= modulo;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= STATE_IDLE;
      a_seen          <= 1'b0;
      b_seen          <= 1'b0;
      size_q          <= '0;
      index           <= '0;
      ready           <= 1'b0;
      data_out_enable <= 1'b0;
      data_out        <= '0;
      mul.start       <= 1'b0;
    end else begin
      // Pulses
      ready           <= 1'b0;
      data_out_enable <= 1'b0;
      mul.start       <= 1'b0;

      case (state)
        STATE_IDLE: begin
          if (start) begin
            size_q <= size;
            index  <= '0;
            a_seen <= 1'b0;
            b_seen <= 1'b0;
            // Empty vector closes at once
            if (size == '0) begin
              ready <= 1'b1;
            end else begin
              state <= STATE_COLLECT;
            end
          end
        end
        STATE_COLLECT: begin
          if (pair_done) begin
            // Launch, flags reset for the next pair
            mul.start <= 1'b1;
            a_seen    <= 1'b0;
            b_seen    <= 1'b0;
            state     <= STATE_WAIT;
          end else begin
            a_seen <= a_done;
            b_seen <= b_done;
          end
        end
        STATE_WAIT: begin
          if (mul.ready) begin
            data_out        <= mul.product;
            data_out_enable <= 1'b1;
            if (last_element) begin
              // End of vector, same cycle as the last result
              ready <= 1'b1;
              state <= STATE_IDLE;
            end else begin
              index <= index + 1'b1;
              state <= STATE_COLLECT;
            end
          end
        end
        default: begin
          state <= STATE_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/modmul_top.sv */
/* Top level of the element-wise modular vector multiplier.
   Plain ports outside; sequencer and scalar multiplier joined by one bus. */

`timescale 1ns/100ps
`default_nettype none

module modmul_top (
  input  logic                              CLK,
  input  logic                              RST,

  // Control
  input  logic                              start,
  output logic                              ready,
  input  logic                              data_a_enable,
  input  logic                              data_b_enable,
  output logic                              data_out_enable,

  // Data
  input  logic [modmul_pkg::DATA_WIDTH-1:0]  modulo,
  input  logic [modmul_pkg::INDEX_WIDTH-1:0] size,
  input  logic [modmul_pkg::DATA_WIDTH-1:0]  data_a,
  input  logic [modmul_pkg::DATA_WIDTH-1:0]  data_b,
  output logic [modmul_pkg::DATA_WIDTH-1:0]  data_out
);

  // One multiply request at a time
  scalar_mul_if mul_bus ();

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  vector_modular_multiplier sequencer0 (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .ready           (ready),
    .data_a_enable   (data_a_enable),
    .data_b_enable   (data_b_enable),
    .data_out_enable (data_out_enable),
    .modulo          (modulo),
    .size            (size),
    .data_a          (data_a),
    .data_b          (data_b),
    .data_out        (data_out),
    .mul             (mul_bus.requester)
  );

  // Scalar multiplier
  scalar_modular_multiplier multiplier0 (
    .CLK (CLK),
    .RST (RST),
    .mul (mul_bus.server)
  );

endmodule

`default_nettype wire

/* test/modmul_tb.sv */
/* Self-checking testbench for modmul_top with seeded random vectors and a model.
   Runs reset, single, random, edge, modulus change and zero length tests in turn. */

`timescale 1ns/100ps
`default_nettype none

module modmul_tb;
  import modmul_pkg::*;

  localparam int RANDOM_VECTORS = 40;
  localparam int MAX_LEN = 16;
  // Full product of A and B fits easily
  localparam int PROD_WIDTH = DATA_WIDTH + ACC_WIDTH;

  // DUT ports
  logic                   CLK;
  logic                   RST;
  logic                   start;
  logic                   ready;
  logic                   data_a_enable;
  logic                   data_b_enable;
  logic                   data_out_enable;
  logic [DATA_WIDTH-1:0]  modulo;
  logic [INDEX_WIDTH-1:0] size;
  logic [DATA_WIDTH-1:0]  data_a;
  logic [DATA_WIDTH-1:0]  data_b;
  logic [DATA_WIDTH-1:0]  data_out;

  // Run bookkeeping
  int                     errors;
  int                     tests;
  int                     test_mark;
  int                     cycle_count;
  int                     cycle_limit;
  int                     elem_count;
  int                     ready_count;
  int                     ready_cycle;
  int                     out_cycle;
  int                     strobe_cycle;
  int                     start_cycle;
  logic [INDEX_WIDTH-1:0] cur_size;
  string                  cur_test;

  // Expected results in output order
  logic [DATA_WIDTH-1:0]  exp_q[$];

  // Operands of the vector being sent
  logic [DATA_WIDTH-1:0]  vec_a[MAX_LEN];
  logic [DATA_WIDTH-1:0]  vec_b[MAX_LEN];
  logic [DATA_WIDTH-1:0]  vec_m[MAX_LEN];
  int                     rand_sizes[RANDOM_VECTORS];

  modmul_top dut0 (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .ready           (ready),
    .data_a_enable   (data_a_enable),
    .data_b_enable   (data_b_enable),
    .data_out_enable (data_out_enable),
    .modulo          (modulo),
    .size            (size),
    .data_a          (data_a),
    .data_b          (data_b),
    .data_out        (data_out)
  );

  // 8 ns period
  always #4 CLK = ~CLK;

  ////////////////////////////////////////////////////////////
  // Model and compare tasks
  ////////////////////////////////////////////////////////////

  function automatic logic [DATA_WIDTH-1:0] model_product(input logic [DATA_WIDTH-1:0] a,
                                                          input logic [DATA_WIDTH-1:0] b,
                                                          input logic [DATA_WIDTH-1:0] m);
    logic [PROD_WIDTH-1:0] full;
    full = PROD_WIDTH'(a) * PROD_WIDTH'(b);
    return DATA_WIDTH'(full % PROD_WIDTH'(m));
  endfunction

  task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] expected,
                            input logic [DATA_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected 0x%h, actual 0x%h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input logic [INDEX_WIDTH-1:0] expected,
                             input logic [INDEX_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Watchdog and output monitor
  ////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("ERROR: simulation timed out waiting for an output");
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // Outputs sampled mid-cycle away from both edges
  always @(negedge CLK) begin
    if (!RST) begin
      if (data_out_enable) begin
        out_cycle = cycle_count;
        if (exp_q.size() == 0) begin
          $display("ERROR %s: output strobe with no element pending", cur_test);
          errors++;
        end else begin
          check_data($sformatf("%s element %0d", cur_test, elem_count), exp_q.pop_front(),
                     data_out);
        end
        elem_count++;
      end
      if (ready) begin
        ready_count++;
        ready_cycle = cycle_count;
      end
      // Ready belongs to the last element and nowhere else
      if (cur_size != '0 && ready != (data_out_enable && elem_count == int'(cur_size))) begin
        $display("ERROR %s: ready does not line up with the last element", cur_test);
        errors++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////

  // Inputs change 1 ns after the rising edge
  task automatic tick();
    @(posedge CLK);
    #1;
  endtask

  task automatic random_gap();
    repeat ($urandom_range(0, 2)) tick();
  endtask

  task automatic pulse_a(input logic [DATA_WIDTH-1:0] value);
    data_a        = value;
    data_a_enable = 1'b1;
    tick();
    data_a_enable = 1'b0;
    data_a        = DATA_WIDTH'($urandom);
  endtask

  task automatic pulse_b(input logic [DATA_WIDTH-1:0] value);
    data_b        = value;
    data_b_enable = 1'b1;
    tick();
    data_b_enable = 1'b0;
    data_b        = DATA_WIDTH'($urandom);
  endtask

  // Operands of one element in the send buffers
  task automatic load_element(input int idx, input logic [DATA_WIDTH-1:0] a,
                              input logic [DATA_WIDTH-1:0] b,
                              input logic [DATA_WIDTH-1:0] m);
    vec_a[idx] = a;
    vec_b[idx] = b;
    vec_m[idx] = m;
  endtask

  // One pair in random order and the wait for its result
  task automatic send_element(input int idx);
    int order;
    modulo = vec_m[idx];
    exp_q.push_back(model_product(vec_a[idx], vec_b[idx], vec_m[idx]));
    order = $urandom_range(0, 2);
    random_gap();
    if (order == 0) begin
      // Sometimes a stale A first that the real one replaces
      if ($urandom_range(0, 3) == 0) begin
        pulse_a(DATA_WIDTH'($urandom));
        random_gap();
      end
      pulse_a(vec_a[idx]);
      random_gap();
      pulse_b(vec_b[idx]);
    end else if (order == 1) begin
      pulse_b(vec_b[idx]);
      random_gap();
      pulse_a(vec_a[idx]);
    end else begin
      data_a        = vec_a[idx];
      data_b        = vec_b[idx];
      data_a_enable = 1'b1;
      data_b_enable = 1'b1;
      tick();
      data_a_enable = 1'b0;
      data_b_enable = 1'b0;
    end
    strobe_cycle = cycle_count;
    // Modulus already taken so it is scrambled during the multiply
    modulo = DATA_WIDTH'($urandom);
    while (elem_count <= idx) tick();
  endtask

  task automatic send_vector(input string name, input int len);
    cur_test    = name;
    cur_size    = INDEX_WIDTH'(len);
    elem_count  = 0;
    ready_count = 0;
    size        = INDEX_WIDTH'(len);
    start       = 1'b1;
    start_cycle = cycle_count;
    tick();
    start       = 1'b0;
    size        = INDEX_WIDTH'($urandom);
    for (int i = 0; i < len; i++) begin
      send_element(i);
    end
    repeat (3) tick();
    check_count({name, " element count"}, INDEX_WIDTH'(len), INDEX_WIDTH'(elem_count));
    if (ready_count != 1) begin
      $display("ERROR %s: ready pulsed %0d times for one vector", name, ready_count);
      errors++;
    end
  endtask

  task automatic begin_test();
    test_mark = errors;
    tests++;
  endtask

  task automatic end_test(input string name);
    if (errors == test_mark) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - test_mark);
    end
  endtask

  task automatic check_outputs_idle(input string name);
    check_data({name, " data_out"}, '0, data_out);
    if (ready || data_out_enable) begin
      $display("ERROR %s: output strobe active without a start", name);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    CLK           = 1'b0;
    RST           = 1'b1;
    start         = 1'b0;
    data_a_enable = 1'b0;
    data_b_enable = 1'b0;
    modulo        = 16'd1;
    size          = '0;
    data_a        = '0;
    data_b        = '0;
    errors        = 0;
    tests         = 0;
    cycle_count   = 0;
    cur_size      = '0;
    cur_test      = "reset";
    void'($urandom(70));

    // Vector lengths drawn first so the cycle limit is known up front
    cycle_limit = 1 + 6 + 8;
    for (int v = 0; v < RANDOM_VECTORS; v++) begin
      rand_sizes[v] = $urandom_range(1, 12);
      cycle_limit += rand_sizes[v];
    end
    cycle_limit = cycle_limit * (DATA_WIDTH + 12) + 500;

    // Reset held over 4 rising edges and a quiet stretch after it
    begin_test();
    repeat (4) begin
      tick();
      check_outputs_idle("reset");
    end
    RST = 1'b0;
    repeat (10) begin
      tick();
      check_outputs_idle("after reset");
    end
    end_test("reset");

    // Single element and its fixed latency
    begin_test();
    vec_a[0] = 16'hbeef;
    vec_b[0] = 16'h1234;
    vec_m[0] = 16'hfff1;
    send_vector("single", 1);
    check_count("single latency", INDEX_WIDTH'(DATA_WIDTH + 3),
                INDEX_WIDTH'(out_cycle - strobe_cycle));
    end_test("single");

    // Random vectors with small moduli now and then
    begin_test();
    for (int v = 0; v < RANDOM_VECTORS; v++) begin
      for (int i = 0; i < rand_sizes[v]; i++) begin
        if ($urandom_range(0, 3) == 0) begin
          vec_m[i] = DATA_WIDTH'($urandom_range(1, 15));
        end else begin
          vec_m[i] = DATA_WIDTH'($urandom_range(1, 65535));
        end
        vec_a[i] = DATA_WIDTH'($urandom);
        vec_b[i] = DATA_WIDTH'($urandom % vec_m[i]);
      end
      send_vector($sformatf("random vector %0d", v), rand_sizes[v]);
    end
    end_test("random");

    // Edge operands
    begin_test();
    load_element(0, 16'd0, 16'd1234, 16'd40000);
    load_element(1, 16'd5555, 16'd0, 16'd777);
    load_element(2, 16'hffff, 16'd0, 16'd1);
    load_element(3, 16'hffff, 16'd65534, 16'd65535);
    load_element(4, 16'd40000, 16'd65520, 16'd65521);
    load_element(5, 16'hffff, 16'd1, 16'd2);
    send_vector("edge operands", 6);
    end_test("edge operands");

    // New modulus for every element of one vector
    begin_test();
    for (int i = 0; i < 8; i++) begin
      vec_m[i] = DATA_WIDTH'($urandom_range(2, 65535));
      vec_a[i] = DATA_WIDTH'($urandom);
      vec_b[i] = DATA_WIDTH'($urandom % vec_m[i]);
    end
    send_vector("modulus change", 8);
    end_test("modulus change");

    // Empty vector with ready one cycle after start
    begin_test();
    send_vector("zero length", 0);
    check_count("zero length ready delay", INDEX_WIDTH'(1),
                INDEX_WIDTH'(ready_cycle - start_cycle));
    end_test("zero length");

    $display("tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
verilog/modmul_pkg.sv
verilog/scalar_mul_if.sv
verilog/scalar_modular_multiplier.sv
verilog/vector_modular_multiplier.sv
verilog/modmul_top.sv
test/modmul_tb.sv

/* run.sh */
#!/bin/sh
# Compile the testbench and RTL with Verilator, run it, judge by the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module modmul_tb -f sim.f -o modmul_sim

output=$(./obj_dir/modmul_sim)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1
